/* source/icache_pkg.sv */
package icache_pkg;

    // cache geometry
    localparam int WAYS           = 4;
    localparam int NUM_SETS       = 16;
    localparam int WORDS_PER_LINE = 8;

    localparam int ADDR_BITS = 32;
    localparam int WORD_BITS = 32;

    // address field widths
    localparam int ALIGN_BITS     = $clog2(WORD_BITS / 8);
    localparam int OFFSET_BITS    = $clog2(WORDS_PER_LINE);
    localparam int INDEX_BITS     = $clog2(NUM_SETS);
    localparam int WAY_BITS       = $clog2(WAYS);
    localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;
    localparam int LINE_BYTE_BITS = OFFSET_BITS + ALIGN_BITS;
    localparam int LINE_BITS      = ADDR_BITS - LINE_BYTE_BITS;

    // data RAM word address: way, set, word
    localparam int DATA_ADDR_BITS = WAY_BITS + INDEX_BITS + OFFSET_BITS;

    typedef logic [WORD_BITS-1:0]   word_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [WAY_BITS-1:0]    way_t;

    // one root bit plus one bit per way pair
    typedef logic [WAYS-2:0] plru_t;

    // fetch address, seen as lookup fields or as line plus byte
    typedef union packed {
        struct packed {
            tag_t                  tag;
            index_t                index;
            offset_t               offset;
            logic [ALIGN_BITS-1:0] align;
        } fields;
        struct packed {
            logic [LINE_BITS-1:0]      line_num;
            logic [LINE_BYTE_BITS-1:0] line_byte;
        } line;
    } ic_addr_u;

    typedef enum logic {
        IDLE,
        FETCH
    } refill_state_e;

endpackage

/* source/icache_tags.sv */
`timescale 1ns/10ps

module icache_tags (
    input  logic                 clk,
    input  logic                 resetn,
    input  icache_pkg::ic_addr_u lookup_addr,
    input  logic                 alloc,
    input  icache_pkg::way_t     alloc_way,
    output logic                 hit,
    output icache_pkg::way_t     hit_way
);

    import icache_pkg::*;

    // valid bits as flops, cleared directly on reset
    logic [NUM_SETS-1:0][WAYS-1:0] valid_q;
    tag_t                          tag_mem [NUM_SETS][WAYS];

    index_t          set_idx;
    tag_t            req_tag;
    logic [WAYS-1:0] way_hit;

    assign set_idx = lookup_addr.fields.index;
    assign req_tag = lookup_addr.fields.tag;

    // compare all ways of the set
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tag_mem[set_idx][w] == req_tag);
        end
    end

    assign hit = |way_hit;

    // at most one way matches, so OR the indices
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = hit_way | way_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
        end else if (alloc) begin
            valid_q[set_idx][alloc_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[set_idx][alloc_way] <= req_tag;
        end
    end

endmodule

/* source/icache_lru.sv */
`timescale 1ns/10ps

module icache_lru (
    input  logic               clk,
    input  logic               resetn,
    input  icache_pkg::index_t index,
    input  logic               touch,
    input  icache_pkg::way_t   touch_way,
    output icache_pkg::way_t   victim_way
);

    import icache_pkg::*;

    plru_t [NUM_SETS-1:0] plru_q;

    plru_t cur_bits;
    plru_t next_bits;

    assign cur_bits = plru_q[index];

    // bit 0 picks the pair, bit 1 the left pair, bit 2 the right pair
    always_comb begin
        if (!cur_bits[0]) begin
            victim_way = {1'b0, cur_bits[1]};
        end else begin
            victim_way = {1'b1, cur_bits[2]};
        end
    end

    // point every bit on the path away from the used way
    always_comb begin
        next_bits    = cur_bits;
        next_bits[0] = ~touch_way[1];
        if (!touch_way[1]) begin
            next_bits[1] = ~touch_way[0];
        end else begin
            next_bits[2] = ~touch_way[0];
        end
    end

    // only accepted hits count as a use
    always_ff @(posedge clk) begin
        if (resetn) begin
            plru_q <= '0;
        end else if (touch) begin
            plru_q[index] <= next_bits;
        end
    end

endmodule

/* source/icache_refill.sv */
`timescale 1ns/10ps

module icache_refill (
    input  logic                                 clk,
    input  logic                                 resetn,

    input  logic                                 ireq_valid,
    input  icache_pkg::ic_addr_u                 ireq_addr,
    output logic                                 iresp_addr_ok,
    output logic                                 iresp_data_ok,

    input  logic                                 hit,
    input  icache_pkg::way_t                     hit_way,
    input  icache_pkg::way_t                     victim_way,
    output logic                                 alloc,
    output icache_pkg::way_t                     alloc_way,
    output logic                                 touch,

    output logic [icache_pkg::DATA_ADDR_BITS-1:0] rd_addr,
    output logic                                 wr_en,
    output logic [icache_pkg::DATA_ADDR_BITS-1:0] wr_addr,
    output icache_pkg::word_t                    wr_data,

    output logic                                 icreq_valid,
    output icache_pkg::ic_addr_u                 icreq_addr,
    input  logic                                 icresp_ready,
    input  icache_pkg::word_t                    icresp_data,
    input  logic                                 icresp_last
);

    import icache_pkg::*;

    refill_state_e state;

    // line under refill
    logic [LINE_BITS-1:0]      line_q;
    offset_t                   start_word;
    offset_t                   word_cnt;
    way_t                      refill_way;
    logic [WORDS_PER_LINE-1:0] arrived;

    ic_addr_u burst_addr;
    logic     miss;
    logic     avail;
    logic     accept;

    assign miss      = ireq_valid && !hit;
    assign alloc     = (state == IDLE) && miss;
    assign alloc_way = victim_way;

    // word can be served unless it is still on its way in
    assign avail = (state == IDLE)
                || (ireq_addr.line.line_num != line_q)
                || arrived[ireq_addr.fields.offset];

    assign accept        = ireq_valid && hit && avail;
    assign iresp_addr_ok = accept;
    assign touch         = accept;

    assign rd_addr = {hit_way, ireq_addr.fields.index, ireq_addr.fields.offset};

    // critical word address, word aligned
    always_comb begin
        burst_addr.line.line_num  = line_q;
        burst_addr.line.line_byte = {start_word, {ALIGN_BITS{1'b0}}};
    end

    assign icreq_valid = (state == FETCH);
    assign icreq_addr  = burst_addr;

    // each ready beat lands in the RAM
    assign wr_en   = (state == FETCH) && icresp_ready;
    assign wr_addr = {refill_way, burst_addr.fields.index, word_cnt};
    assign wr_data = icresp_data;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state   <= IDLE;
            arrived <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (miss) begin
                        state   <= FETCH;
                        arrived <= '0;
                    end
                end
                FETCH: begin
                    if (icresp_ready) begin
                        arrived[word_cnt] <= 1'b1;
                        if (icresp_last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // latched on the miss, word number wraps inside the line
    always_ff @(posedge clk) begin
        if (alloc) begin
            line_q     <= ireq_addr.line.line_num;
            start_word <= ireq_addr.line.line_byte[LINE_BYTE_BITS-1:ALIGN_BITS];
            word_cnt   <= ireq_addr.line.line_byte[LINE_BYTE_BITS-1:ALIGN_BITS];
            refill_way <= victim_way;
        end else if (wr_en) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // RAM read data shows up one cycle after the accept
    always_ff @(posedge clk) begin
        if (resetn) begin
            iresp_data_ok <= 1'b0;
        end else begin
            iresp_data_ok <= accept;
        end
    end

endmodule

/* source/icache_data_ram.sv */
`timescale 1ns/10ps

module icache_data_ram #(
    parameter int DEPTH = 512,
    parameter int WIDTH = 32
) (
    input  logic                     clk,

    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data,

    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* source/icache_top.sv */
`timescale 1ns/10ps

module icache_top (
    input  logic              clk,
    input  logic              resetn,

    input  logic              ireq_valid,
    input  logic [31:0]       ireq_addr,
    output logic              iresp_addr_ok,
    output logic              iresp_data_ok,
    output icache_pkg::word_t iresp_data,

    output logic              icreq_valid,
    output logic [31:0]       icreq_addr,
    input  logic              icresp_ready,
    input  icache_pkg::word_t icresp_data,
    input  logic              icresp_last
);

    import icache_pkg::*;

    ic_addr_u fetch_addr;

    logic hit;
    way_t hit_way;
    way_t victim_way;
    logic alloc;
    way_t alloc_way;
    logic touch;

    logic [DATA_ADDR_BITS-1:0] rd_addr;
    logic [DATA_ADDR_BITS-1:0] wr_addr;
    logic                      wr_en;
    word_t                     wr_data;

    assign fetch_addr = ireq_addr;

    icache_tags i_icache_tags (
        .clk         (clk),
        .resetn      (resetn),
        .lookup_addr (fetch_addr),
        .alloc       (alloc),
        .alloc_way   (alloc_way),
        .hit         (hit),
        .hit_way     (hit_way)
    );

    icache_lru i_icache_lru (
        .clk        (clk),
        .resetn     (resetn),
        .index      (fetch_addr.fields.index),
        .touch      (touch),
        .touch_way  (hit_way),
        .victim_way (victim_way)
    );

    icache_refill i_icache_refill (
        .clk           (clk),
        .resetn        (resetn),
        .ireq_valid    (ireq_valid),
        .ireq_addr     (fetch_addr),
        .iresp_addr_ok (iresp_addr_ok),
        .iresp_data_ok (iresp_data_ok),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .alloc         (alloc),
        .alloc_way     (alloc_way),
        .touch         (touch),
        .rd_addr       (rd_addr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .icreq_valid   (icreq_valid),
        .icreq_addr    (icreq_addr),
        .icresp_ready  (icresp_ready),
        .icresp_data   (icresp_data),
        .icresp_last   (icresp_last)
    );

    // one word per entry, all ways and sets
    icache_data_ram #(
        .DEPTH (WAYS * NUM_SETS * WORDS_PER_LINE),
        .WIDTH ($bits(word_t))
    ) i_icache_data_ram (
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (iresp_data),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data)
    );

endmodule

/* test/icache_asserts.sv */
`timescale 1ns/10ps

module icache_asserts (
    input logic                 clk,
    input logic                 resetn,
    input icache_pkg::ic_addr_u ireq_addr,
    input logic                 iresp_addr_ok,
    input logic                 iresp_data_ok,
    input logic                 icreq_valid,
    input icache_pkg::ic_addr_u icreq_addr,
    input logic                 icresp_ready,
    input logic                 icresp_last
);

    import icache_pkg::*;

    int fail_count = 0;

    // words of the running burst already taken
    logic [WORDS_PER_LINE-1:0] seen;
    offset_t                   beats;

    always_ff @(posedge clk) begin
        if (resetn || !icreq_valid) begin
            seen  <= '0;
            beats <= '0;
        end else if (icresp_ready) begin
            seen[icreq_addr.fields.offset + beats] <= 1'b1;
            beats <= beats + 1'b1;
        end
    end

    data_ok_follows: assert property (@(posedge clk) disable iff (resetn)
        iresp_addr_ok |=> iresp_data_ok)
        else begin
            $error("data_ok missing one cycle after addr_ok");
            fail_count++;
        end

    data_ok_only_after: assert property (@(posedge clk) disable iff (resetn)
        iresp_data_ok |-> $past(iresp_addr_ok))
        else begin
            $error("data_ok without addr_ok in the cycle before");
            fail_count++;
        end

    burst_stable: assert property (@(posedge clk) disable iff (resetn)
        icreq_valid && !(icresp_ready && icresp_last) |=> icreq_valid && $stable(icreq_addr))
        else begin
            $error("burst request changed before the last beat");
            fail_count++;
        end

    word_arrived: assert property (@(posedge clk) disable iff (resetn)
        iresp_addr_ok && icreq_valid && ireq_addr.line.line_num == icreq_addr.line.line_num
        |-> seen[ireq_addr.fields.offset])
        else begin
            $error("addr_ok for a word that has not arrived");
            fail_count++;
        end

endmodule

bind icache_refill icache_asserts i_icache_asserts (
    .clk           (clk),
    .resetn        (resetn),
    .ireq_addr     (ireq_addr),
    .iresp_addr_ok (iresp_addr_ok),
    .iresp_data_ok (iresp_data_ok),
    .icreq_valid   (icreq_valid),
    .icreq_addr    (icreq_addr),
    .icresp_ready  (icresp_ready),
    .icresp_last   (icresp_last)
);

/* test/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb;

    localparam int          NUM_FETCHES    = 19;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          SEED           = 32'h5498_95d1;
    localparam logic [31:0] PATTERN_KEY    = 32'hA5C3_0F1E;

    // bit 32 is the expected refill, bits 31..0 the fetch address
    localparam logic [32:0] FETCH_TABLE [NUM_FETCHES] = '{
        {1'b1, 32'h0000_1004},  // set 0, critical word 1
        {1'b0, 32'h0000_1018},
        {1'b1, 32'h0000_20AC},  // line A in set 5 goes to way 0
        {1'b0, 32'h0000_1008},  // other line while A streams in
        {1'b0, 32'h0000_20B0},
        {1'b0, 32'h0000_20BC},
        {1'b0, 32'h0000_20A0},  // wraps past the end of the line
        {1'b0, 32'h0000_20A8},
        {1'b1, 32'h0000_40A0},  // B to way 2
        {1'b1, 32'h0000_60B8},  // C to way 1
        {1'b1, 32'h0000_80BC},  // D to way 3, tree bits back to zero
        {1'b1, 32'h0000_A0A4},  // E evicts A from way 0
        {1'b0, 32'h0000_60A0},
        {1'b0, 32'h0000_80A4},
        {1'b0, 32'h0000_A0B0},
        {1'b1, 32'h0000_20AC},  // A again, victim is B in way 2
        {1'b1, 32'h0000_40A4},  // B now misses, C in way 1 goes
        {1'b0, 32'h0000_80B8},
        {1'b0, 32'h0000_20B4}
    };

    logic        clk          = 1'b0;
    logic        resetn       = 1'b1;
    logic        ireq_valid   = 1'b0;
    logic [31:0] ireq_addr    = '0;
    logic        iresp_addr_ok;
    logic        iresp_data_ok;
    logic [31:0] iresp_data;
    logic        icreq_valid;
    logic [31:0] icreq_addr;
    logic        icresp_ready = 1'b0;
    logic [31:0] icresp_data  = '0;
    logic        icresp_last  = 1'b0;

    int mismatch_count = 0;
    int timeout_count  = 0;

    // memory model state
    logic        busy       = 1'b0;
    logic [3:0]  beat_idx   = '0;
    logic [2:0]  start_word = '0;
    logic [26:0] burst_line = '1;
    logic [7:0]  delivered  = '0;
    int          burst_count = 0;
    int          bursts_done = 0;

    // bus request as seen at the falling edge
    logic        req_seen      = 1'b0;
    logic [31:0] req_addr_seen = '0;
    int          checked_done  = 0;
    logic [31:0] cur_addr      = '0;

    icache_top i_icache_top (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] pattern_word(input logic [31:0] addr);
        return addr ^ PATTERN_KEY;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            mismatch_count++;
        end
    endtask

    // burst answers wrap from the critical word
    always @(posedge clk) begin
        if (resetn) begin
            busy = 1'b0;
            icresp_ready <= 1'b0;
            icresp_last  <= 1'b0;
        end else begin
            if (busy) begin
                if (icresp_ready) begin
                    delivered[start_word + beat_idx[2:0]] = 1'b1;
                    beat_idx = beat_idx + 4'd1;
                    if (icresp_last) begin
                        busy = 1'b0;
                        bursts_done++;
                    end
                end
            end else if (req_seen) begin
                check_equal(req_addr_seen, {cur_addr[31:2], 2'b00}, "burst start address");
                busy       = 1'b1;
                beat_idx   = '0;
                start_word = req_addr_seen[4:2];
                burst_line = req_addr_seen[31:5];
                delivered  = '0;
                burst_count++;
            end
            if (busy) begin
                icresp_ready <= ($urandom % 4) != 0;
                icresp_data  <= pattern_word({burst_line, start_word + beat_idx[2:0], 2'b00});
                icresp_last  <= beat_idx == 4'd7;
            end else begin
                icresp_ready <= 1'b0;
                icresp_last  <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (bursts_done != checked_done) begin
            // engine is idle right after the last beat
            check_equal(32'(icreq_valid), 32'd0, "icreq_valid after last beat");
            checked_done = bursts_done;
        end
        req_seen      = icreq_valid;
        req_addr_seen = icreq_addr;
    end

    task automatic run_fetch(input logic [31:0] addr, input logic refill);
        int   bursts_before;
        int   waited;
        logic accepted;
        cur_addr      = addr;
        bursts_before = burst_count;
        @(posedge clk);
        ireq_valid <= 1'b1;
        ireq_addr  <= addr;
        waited = 0;
        @(negedge clk);
        while (!iresp_addr_ok && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        accepted = iresp_addr_ok;
        if (accepted) begin
            check_equal(32'(burst_count - bursts_before), 32'(refill),
                        $sformatf("bursts for fetch %h", addr));
            if (addr[31:5] == burst_line) begin
                check_equal(32'(delivered[addr[4:2]]), 32'd1,
                            $sformatf("fetch %h accepted before its beat", addr));
            end
        end else begin
            $display("Timeout: fetch of %h was never accepted", addr);
            timeout_count++;
        end
        @(posedge clk);
        ireq_valid <= 1'b0;
        @(negedge clk);
        if (accepted) begin
            check_equal(32'(iresp_data_ok), 32'd1, $sformatf("data_ok for %h", addr));
            check_equal(iresp_data, pattern_word(addr), $sformatf("data for %h", addr));
        end
    endtask

    initial begin
        int waited;
        void'($urandom(SEED));
        repeat (10) @(posedge clk);
        resetn <= 1'b0;
        @(negedge clk);
        check_equal(32'(iresp_addr_ok), 32'd0, "iresp_addr_ok after reset");
        check_equal(32'(iresp_data_ok), 32'd0, "iresp_data_ok after reset");
        check_equal(32'(icreq_valid), 32'd0, "icreq_valid after reset");

        for (int i = 0; i < NUM_FETCHES; i++) begin
            run_fetch(FETCH_TABLE[i][31:0], FETCH_TABLE[i][32]);
        end

        waited = 0;
        while (busy && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            $display("Timeout: the last burst never finished");
            timeout_count++;
        end
        repeat (2) @(negedge clk);

        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count,
                 i_icache_top.i_icache_refill.i_icache_asserts.fail_count);
        if (mismatch_count == 0 && timeout_count == 0 &&
            i_icache_top.i_icache_refill.i_icache_asserts.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sources.f */
source/icache_pkg.sv
source/icache_tags.sv
source/icache_lru.sv
source/icache_refill.sv
source/icache_data_ram.sv
source/icache_top.sv
test/icache_asserts.sv
test/icache_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module icache_tb -f sources.f -o icache_sim \
    && ./obj_dir/icache_sim +verilator+error+limit+100 | tee /dev/stderr \
    | grep -x "Testbench passed" > /dev/null \
    || { echo "simulation did not pass" >&2; exit 1; }
